/* Bender.yml */
package:
  name: alu_cluster

sources:
  - alu_pkg.sv
  - rv32_alu.sv
  - alu_lane.sv
  - alu_dispatcher.sv
  - alu_collector.sv
  - alu_axil_regs.sv
  - alu_cluster_top.sv
  - target: simulation
    files:
      - alu_cluster_assertions.sv
      - tb_alu_cluster.sv

/* alu_axil_regs.sv */
`timescale 1ns/1ps

module alu_axil_regs
    import alu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [ADDR_W-1:0]    awaddr,
    input  logic                 wvalid,
    output logic                 wready,
    input  logic [31:0]          wdata,
    input  logic [3:0]           wstrb,
    output logic                 bvalid,
    input  logic                 bready,
    output logic [1:0]           bresp,
    input  logic                 arvalid,
    output logic                 arready,
    input  logic [ADDR_W-1:0]    araddr,
    output logic                 rvalid,
    input  logic                 rready,
    output logic [31:0]          rdata,
    output logic [1:0]           rresp,
    output logic                 cmd_valid,
    input  logic                 cmd_ready,
    output alu_op_e              cmd_op,
    output logic                 cmd_sub_sra,
    output alu_src1_e            cmd_src1,
    output alu_src2_e            cmd_src2,
    output logic [31:0]          cmd_pc,
    output logic [31:0]          cmd_rs1_value,
    output logic [31:0]          cmd_rs2_value,
    output logic [31:0]          cmd_imm,
    input  logic                 res_valid,
    input  logic [31:0]          res_data,
    input  logic [RES_CNT_W-1:0] res_count,
    output logic                 res_pop
);
    logic        wr_fire;
    logic        wr_en;
    logic        rd_fire;
    logic [31:0] status;

    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    // Any strobe counts as a full-word write; an all-zero strobe writes nothing.
    assign wr_en     = wr_fire && (wstrb != 4'b0000);
    assign cmd_valid = wr_en && (awaddr == ADDR_CTRL);

    assign cmd_op      = alu_op_e'(wdata[2:0]);
    assign cmd_sub_sra = wdata[3];
    assign cmd_src1    = alu_src1_e'(wdata[5:4]);
    assign cmd_src2    = alu_src2_e'(wdata[7:6]);

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid        <= 1'b0;
            cmd_rs1_value <= '0;
            cmd_rs2_value <= '0;
            cmd_imm       <= '0;
            cmd_pc        <= '0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
            bresp  <= (cmd_valid && !cmd_ready) ? RESP_SLVERR : RESP_OKAY;
            if (wr_en) begin
                case (awaddr)
                    ADDR_RS1: cmd_rs1_value <= wdata;
                    ADDR_RS2: cmd_rs2_value <= wdata;
                    ADDR_IMM: cmd_imm       <= wdata;
                    ADDR_PC:  cmd_pc        <= wdata;
                    default: ;
                endcase
            end
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;
    assign res_pop = rd_fire && (araddr == ADDR_RESULT) && res_valid;

    always_comb begin
        status                 = '0;
        status[0]              = res_valid;
        status[1]              = !cmd_ready;
        status[8 +: RES_CNT_W] = res_count;
    end

    always_ff @(posedge clk) begin
        if (reset)
            rvalid <= 1'b0;
        else if (rd_fire)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // An empty result queue reads back as zero with an error response.
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rresp <= RESP_OKAY;
            case (araddr)
                ADDR_RESULT: begin
                    rdata <= res_valid ? res_data : 32'd0;
                    rresp <= res_valid ? RESP_OKAY : RESP_SLVERR;
                end
                ADDR_STATUS: rdata <= status;
                default:     rdata <= '0;
            endcase
        end
    end

endmodule

/* alu_cluster_assertions.sv */
`timescale 1ns/1ps

module alu_cluster_assertions
    import alu_pkg::*;
(
    input logic                 clk,
    input logic                 reset,
    input logic                 bvalid,
    input logic                 bready,
    input logic [1:0]           bresp,
    input logic                 rvalid,
    input logic                 rready,
    input logic [31:0]          rdata,
    input logic [1:0]           rresp,
    input logic [RES_CNT_W-1:0] res_count
);
    int unsigned fail_count = 0;

    // A write response holds with a stable code until the host takes it.
    b_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
        fail_count++;
        $error("bvalid dropped or bresp changed before bready");
    end

    r_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
        fail_count++;
        $error("rvalid dropped or read data changed before rready");
    end

    resp_idle_after_reset: assert property (@(posedge clk) reset |=> !bvalid && !rvalid)
    else begin
        fail_count++;
        $error("bvalid or rvalid high in the cycle after reset");
    end

    res_bound: assert property (@(posedge clk) disable iff (reset) res_count <= RES_DEPTH)
    else begin
        fail_count++;
        $error("result count above queue depth");
    end

endmodule

bind alu_cluster_top alu_cluster_assertions i_assertions (.*);

/* alu_cluster_top.sv */
`timescale 1ns/1ps

module alu_cluster_top
    import alu_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              awvalid,
    output logic              awready,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    input  logic              arvalid,
    output logic              arready,
    input  logic [ADDR_W-1:0] araddr,
    output logic              rvalid,
    input  logic              rready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp
);
    logic                       cmd_valid;
    logic                       cmd_ready;
    alu_op_e                    cmd_op;
    logic                       cmd_sub_sra;
    alu_src1_e                  cmd_src1;
    alu_src2_e                  cmd_src2;
    logic [31:0]                cmd_pc;
    logic [31:0]                cmd_rs1_value;
    logic [31:0]                cmd_rs2_value;
    logic [31:0]                cmd_imm;
    logic [NUM_LANES-1:0]       lane_in_valid;
    logic [NUM_LANES-1:0]       lane_in_ready;
    alu_op_e                    lane_op;
    logic                       lane_sub_sra;
    alu_src1_e                  lane_src1;
    alu_src2_e                  lane_src2;
    logic [31:0]                lane_pc;
    logic [31:0]                lane_rs1_value;
    logic [31:0]                lane_rs2_value;
    logic [31:0]                lane_imm;
    logic [NUM_LANES-1:0]       lane_out_valid;
    logic [NUM_LANES-1:0]       lane_out_ready;
    logic [NUM_LANES-1:0][31:0] lane_out_data;
    logic                       res_valid;
    logic [31:0]                res_data;
    logic                       res_pop;
    logic [RES_CNT_W-1:0]       res_count;

    alu_axil_regs i_regs (.*);

    alu_dispatcher i_dispatcher (.*);

    // All lanes share the head command; only the selected lane sees in_valid.
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        alu_lane i_lane (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (lane_in_valid[i]),
            .in_ready  (lane_in_ready[i]),
            .op        (lane_op),
            .sub_sra   (lane_sub_sra),
            .src1      (lane_src1),
            .src2      (lane_src2),
            .pc        (lane_pc),
            .rs1_value (lane_rs1_value),
            .rs2_value (lane_rs2_value),
            .imm       (lane_imm),
            .out_valid (lane_out_valid[i]),
            .out_ready (lane_out_ready[i]),
            .out_data  (lane_out_data[i])
        );
    end

    alu_collector i_collector (.*);

endmodule

/* alu_collector.sv */
`timescale 1ns/1ps

module alu_collector
    import alu_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [NUM_LANES-1:0]       lane_out_valid,
    output logic [NUM_LANES-1:0]       lane_out_ready,
    input  logic [NUM_LANES-1:0][31:0] lane_out_data,
    output logic                       res_valid,
    output logic [31:0]                res_data,
    input  logic                       res_pop,
    output logic [RES_CNT_W-1:0]       res_count
);
    logic [31:0]          mem [RES_DEPTH];
    logic [RES_PTR_W-1:0] wr_ptr;
    logic [RES_PTR_W-1:0] rd_ptr;
    logic [RES_CNT_W-1:0] count;
    logic [LANE_W-1:0]    rr_ptr;
    logic                 room;
    logic                 take;
    logic                 pop;

    assign pop  = res_pop && res_valid;
    assign room = (count != RES_DEPTH) || pop;
    assign take = lane_out_valid[rr_ptr] && room;

    // Draining in dispatch order keeps results in issue order.
    always_comb begin
        lane_out_ready         = '0;
        lane_out_ready[rr_ptr] = room;
    end

    assign res_valid = (count != 0);
    assign res_data  = mem[rd_ptr];
    assign res_count = count;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rr_ptr <= '0;
        end else begin
            if (take) begin
                wr_ptr <= wr_ptr + 1'b1;
                rr_ptr <= (rr_ptr == NUM_LANES - 1) ? '0 : rr_ptr + 1'b1;
            end
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + take - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            mem[wr_ptr] <= lane_out_data[rr_ptr];
    end

endmodule

/* alu_dispatcher.sv */
`timescale 1ns/1ps

module alu_dispatcher
    import alu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  alu_op_e              cmd_op,
    input  logic                 cmd_sub_sra,
    input  alu_src1_e            cmd_src1,
    input  alu_src2_e            cmd_src2,
    input  logic [31:0]          cmd_pc,
    input  logic [31:0]          cmd_rs1_value,
    input  logic [31:0]          cmd_rs2_value,
    input  logic [31:0]          cmd_imm,
    output logic [NUM_LANES-1:0] lane_in_valid,
    input  logic [NUM_LANES-1:0] lane_in_ready,
    output alu_op_e              lane_op,
    output logic                 lane_sub_sra,
    output alu_src1_e            lane_src1,
    output alu_src2_e            lane_src2,
    output logic [31:0]          lane_pc,
    output logic [31:0]          lane_rs1_value,
    output logic [31:0]          lane_rs2_value,
    output logic [31:0]          lane_imm
);
    alu_op_e   q_op      [CMD_DEPTH];
    logic      q_sub_sra [CMD_DEPTH];
    alu_src1_e q_src1    [CMD_DEPTH];
    alu_src2_e q_src2    [CMD_DEPTH];
    logic [31:0] q_pc    [CMD_DEPTH];
    logic [31:0] q_rs1   [CMD_DEPTH];
    logic [31:0] q_rs2   [CMD_DEPTH];
    logic [31:0] q_imm   [CMD_DEPTH];

    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_CNT_W-1:0] count;
    logic [LANE_W-1:0]    rr_ptr;
    logic                 push;
    logic                 issue;

    assign cmd_ready = (count != CMD_DEPTH);
    assign push      = cmd_valid && cmd_ready;
    assign issue     = (count != 0) && lane_in_ready[rr_ptr];

    // Only the lane under the pointer sees the head command as valid.
    always_comb begin
        lane_in_valid         = '0;
        lane_in_valid[rr_ptr] = (count != 0);
    end

    assign lane_op        = q_op[rd_ptr];
    assign lane_sub_sra   = q_sub_sra[rd_ptr];
    assign lane_src1      = q_src1[rd_ptr];
    assign lane_src2      = q_src2[rd_ptr];
    assign lane_pc        = q_pc[rd_ptr];
    assign lane_rs1_value = q_rs1[rd_ptr];
    assign lane_rs2_value = q_rs2[rd_ptr];
    assign lane_imm       = q_imm[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rr_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (issue) begin
                rd_ptr <= rd_ptr + 1'b1;
                rr_ptr <= (rr_ptr == NUM_LANES - 1) ? '0 : rr_ptr + 1'b1;
            end
            count <= count + push - issue;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_op[wr_ptr]      <= cmd_op;
            q_sub_sra[wr_ptr] <= cmd_sub_sra;
            q_src1[wr_ptr]    <= cmd_src1;
            q_src2[wr_ptr]    <= cmd_src2;
            q_pc[wr_ptr]      <= cmd_pc;
            q_rs1[wr_ptr]     <= cmd_rs1_value;
            q_rs2[wr_ptr]     <= cmd_rs2_value;
            q_imm[wr_ptr]     <= cmd_imm;
        end
    end

endmodule

/* alu_lane.sv */
`timescale 1ns/1ps

module alu_lane
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  alu_op_e     op,
    input  logic        sub_sra,
    input  alu_src1_e   src1,
    input  alu_src2_e   src2,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_value,
    input  logic [31:0] rs2_value,
    input  logic [31:0] imm,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] out_data
);
    logic        stg_valid;
    alu_op_e     stg_op;
    logic        stg_sub_sra;
    alu_src1_e   stg_src1;
    alu_src2_e   stg_src2;
    logic [31:0] stg_pc;
    logic [31:0] stg_rs1;
    logic [31:0] stg_rs2;
    logic [31:0] stg_imm;
    logic [31:0] alu_result;
    logic        advance;

    // The operand stage moves on when the result stage is free or drains now.
    assign advance  = stg_valid && (!out_valid || out_ready);
    assign in_ready = !stg_valid || advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            stg_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (in_ready)
                stg_valid <= in_valid;
            if (advance)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            stg_op      <= op;
            stg_sub_sra <= sub_sra;
            stg_src1    <= src1;
            stg_src2    <= src2;
            stg_pc      <= pc;
            stg_rs1     <= rs1_value;
            stg_rs2     <= rs2_value;
            stg_imm     <= imm;
        end
        if (advance)
            out_data <= alu_result;
    end

    rv32_alu i_alu (
        .op        (stg_op),
        .sub_sra   (stg_sub_sra),
        .src1      (stg_src1),
        .src2      (stg_src2),
        .pc        (stg_pc),
        .rs1_value (stg_rs1),
        .rs2_value (stg_rs2),
        .imm       (stg_imm),
        .result    (alu_result)
    );

endmodule

/* alu_pkg.sv */
package alu_pkg;

    localparam int NUM_LANES = 4;
    localparam int CMD_DEPTH = 4;
    localparam int RES_DEPTH = 8;

    localparam int LANE_W    = $clog2(NUM_LANES);
    localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
    localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);
    localparam int RES_PTR_W = $clog2(RES_DEPTH);
    localparam int RES_CNT_W = $clog2(RES_DEPTH + 1);

    localparam int ADDR_W = 5;

    localparam logic [ADDR_W-1:0] ADDR_RS1    = 5'h00;
    localparam logic [ADDR_W-1:0] ADDR_RS2    = 5'h04;
    localparam logic [ADDR_W-1:0] ADDR_IMM    = 5'h08;
    localparam logic [ADDR_W-1:0] ADDR_PC     = 5'h0C;
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 5'h10;
    localparam logic [ADDR_W-1:0] ADDR_RESULT = 5'h14;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 5'h18;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        XOR     = 3'b001,
        OR      = 3'b010,
        AND     = 3'b011,
        SLL     = 3'b100,
        SRL_SRA = 3'b101,
        SLT     = 3'b110,
        SLTU    = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_REG = 2'b00, SRC1_PC = 2'b01, SRC1_ZERO = 2'b10} alu_src1_e;

    typedef enum logic [1:0] {SRC2_REG = 2'b00, SRC2_IMM = 2'b01, SRC2_FOUR = 2'b10} alu_src2_e;

endpackage

/* rv32_alu.sv */
`timescale 1ns/1ps

module rv32_alu
    import alu_pkg::*;
(
    input  alu_op_e     op,
    input  logic        sub_sra,
    input  alu_src1_e   src1,
    input  alu_src2_e   src2,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_value,
    input  logic [31:0] rs2_value,
    input  logic [31:0] imm,
    output logic [31:0] result
);
    logic [31:0] opa;
    logic [31:0] opb;
    logic [4:0]  shamt;
    logic [32:0] diff;
    logic [31:0] add_sub;
    logic [32:0] shr;
    logic        ovf;
    logic        lt;
    logic        ltu;

    always_comb begin
        case (src1)
            SRC1_REG:  opa = rs1_value;
            SRC1_PC:   opa = pc;
            SRC1_ZERO: opa = '0;
            default:   opa = '0;
        endcase

        case (src2)
            SRC2_REG:  opb = rs2_value;
            SRC2_IMM:  opb = imm;
            SRC2_FOUR: opb = 32'd4;
            default:   opb = '0;
        endcase
    end

    assign shamt = opb[4:0];

    // The zero-extended difference carries the unsigned borrow in bit 32.
    assign diff    = {1'b0, opa} - {1'b0, opb};
    assign add_sub = sub_sra ? diff[31:0] : opa + opb;

    // Bit 32 is the fill bit, so one signed shift covers both srl and sra.
    assign shr = $signed({sub_sra & opa[31], opa}) >>> shamt;

    assign ovf = (opa[31] != opb[31]) && (diff[31] != opa[31]);
    assign lt  = diff[31] ^ ovf;
    assign ltu = diff[32];

    always_comb begin
        case (op)
            ADD_SUB: result = add_sub;
            XOR:     result = opa ^ opb;
            OR:      result = opa | opb;
            AND:     result = opa & opb;
            SLL:     result = opa << shamt;
            SRL_SRA: result = shr[31:0];
            SLT:     result = {31'b0, lt};
            SLTU:    result = {31'b0, ltu};
            default: result = '0;
        endcase
    end

endmodule

/* sim.f */
alu_pkg.sv
rv32_alu.sv
alu_lane.sv
alu_dispatcher.sv
alu_collector.sv
alu_axil_regs.sv
alu_cluster_top.sv
alu_cluster_assertions.sv
tb_alu_cluster.sv

/* tb_alu_cluster.sv */
`timescale 1ns/1ps

module tb_alu_cluster
    import alu_pkg::*;
();
    localparam int TOTAL_CMDS = 60 + 4 + 12 + 21;
    localparam int POLL_LIMIT = 200;

    logic              clk;
    logic              reset;
    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic              wready;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic              bvalid;
    logic              bready;
    logic [1:0]        bresp;
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;
    logic              rvalid;
    logic              rready;
    logic [31:0]       rdata;
    logic [1:0]        rresp;
    logic [31:0]       exp_q [$];

    alu_cluster_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED %s got 0x%01h expected 0x%01h", name, got, exp));
    endtask

    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = 4'hF;
        @(negedge clk);
        while (!(awready && wready)) begin
            n++;
            if (n > POLL_LIMIT)
                report_failure("The write address and data handshake never completed.");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) begin
            n++;
            if (n > POLL_LIMIT)
                report_failure("No write response arrived.");
            @(negedge clk);
        end
        resp = bresp;
        // The response waits a cycle before bready takes it, so the slave has to hold it.
        @(posedge clk);
        #1;
        bready = 1'b1;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge clk);
        while (!arready) begin
            n++;
            if (n > POLL_LIMIT)
                report_failure("The read address handshake never completed.");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) begin
            n++;
            if (n > POLL_LIMIT)
                report_failure("No read response arrived.");
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        // Read data also waits a cycle before rready accepts it.
        @(posedge clk);
        #1;
        rready = 1'b1;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // RV32I behavior as the ISA defines it, including operand selection.
    function automatic logic [31:0] alu_model(input alu_op_e op, input logic sub_sra,
                                              input alu_src1_e s1, input alu_src2_e s2,
                                              input logic [31:0] rs1, rs2, imm, pc);
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [31:0] sa;
        a  = (s1 == SRC1_PC) ? pc : ((s1 == SRC1_ZERO) ? 32'd0 : rs1);
        b  = (s2 == SRC2_IMM) ? imm : ((s2 == SRC2_FOUR) ? 32'd4 : rs2);
        sa = a;
        case (op)
            ADD_SUB: return sub_sra ? a - b : a + b;
            XOR:     return a ^ b;
            OR:      return a | b;
            AND:     return a & b;
            SLL:     return a << b[4:0];
            SRL_SRA: begin
                if (sub_sra)
                    return sa >>> b[4:0];
                return a >> b[4:0];
            end
            SLT:     return {31'd0, $signed(a) < $signed(b)};
            SLTU:    return {31'd0, a < b};
            default: return 32'd0;
        endcase
    endfunction

    task automatic issue_cmd(input alu_op_e op, input logic sub_sra, input alu_src1_e s1,
                             input alu_src2_e s2, input logic [31:0] rs1, rs2, imm, pc,
                             input logic [1:0] exp_resp);
        logic [1:0] resp;
        axil_write(ADDR_RS1, rs1, resp);
        check_resp("BRESP", resp, RESP_OKAY);
        axil_write(ADDR_RS2, rs2, resp);
        check_resp("BRESP", resp, RESP_OKAY);
        axil_write(ADDR_IMM, imm, resp);
        check_resp("BRESP", resp, RESP_OKAY);
        axil_write(ADDR_PC, pc, resp);
        check_resp("BRESP", resp, RESP_OKAY);
        axil_write(ADDR_CTRL, {24'd0, s2, s1, sub_sra, op}, resp);
        check_resp("BRESP", resp, exp_resp);
        if (exp_resp == RESP_OKAY)
            exp_q.push_back(alu_model(op, sub_sra, s1, s2, rs1, rs2, imm, pc));
    endtask

    task automatic issue_random_cmd(input logic [1:0] exp_resp);
        logic [31:0] rnd;
        rnd = $urandom();
        issue_cmd(alu_op_e'(rnd[2:0]), rnd[3], SRC1_REG, SRC2_REG, $urandom(), $urandom(),
                  $urandom(), $urandom(), exp_resp);
    endtask

    task automatic wait_status(input int bit_idx, input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        int          n;
        n = 0;
        axil_read(ADDR_STATUS, data, resp);
        while (!data[bit_idx]) begin
            n++;
            if (n > POLL_LIMIT)
                report_failure($sformatf("STATUS never showed %s.", what));
            axil_read(ADDR_STATUS, data, resp);
        end
    endtask

    task automatic read_result();
        logic [31:0] data;
        logic [1:0]  resp;
        wait_status(0, "an available result");
        axil_read(ADDR_RESULT, data, resp);
        check_resp("RRESP", resp, RESP_OKAY);
        if (exp_q.size() == 0)
            report_failure("A result was read with no command outstanding.");
        check_data("RESULT", data, exp_q.pop_front());
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(ADDR_STATUS, data, resp);
        check_data("STATUS", data, 32'h0);
        axil_read(ADDR_RESULT, data, resp);
        check_resp("RRESP", resp, RESP_SLVERR);
        check_data("RESULT", data, 32'h0);
    endtask

    task automatic test_opcodes();
        logic [31:0] a_vals [6];
        logic [31:0] b_vals [6];
        logic [31:0] a;
        logic [31:0] b;
        alu_op_e     op;
        a_vals = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000, 32'h8000_0000, 32'h0, 32'h0};
        b_vals = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'd31, 32'd0, 32'h0};
        for (int v = 0; v < 10; v++) begin
            // Variants 8 and 9 are sub and sra.
            op = (v < 8) ? alu_op_e'(v[2:0]) : ((v == 8) ? ADD_SUB : SRL_SRA);
            for (int p = 0; p < 6; p++) begin
                a = (p >= 4) ? $urandom() : a_vals[p];
                b = (p == 5) ? $urandom() : b_vals[p];
                issue_cmd(op, v >= 8, SRC1_REG, SRC2_REG, a, b, $urandom(), $urandom(),
                          RESP_OKAY);
                read_result();
            end
        end
    endtask

    task automatic test_sources();
        issue_cmd(ADD_SUB, 1'b0, SRC1_PC, SRC2_IMM, $urandom(), $urandom(), $urandom(),
                  $urandom(), RESP_OKAY);
        read_result();
        issue_cmd(ADD_SUB, 1'b0, SRC1_PC, SRC2_FOUR, $urandom(), $urandom(), $urandom(),
                  $urandom(), RESP_OKAY);
        read_result();
        issue_cmd(ADD_SUB, 1'b0, SRC1_ZERO, SRC2_IMM, $urandom(), $urandom(), $urandom(),
                  $urandom(), RESP_OKAY);
        read_result();
        issue_cmd(SLT, 1'b0, SRC1_REG, SRC2_IMM, $urandom(), $urandom(), $urandom(),
                  $urandom(), RESP_OKAY);
        read_result();
    endtask

    task automatic test_burst();
        for (int i = 0; i < 12; i++)
            issue_random_cmd(RESP_OKAY);
        for (int i = 0; i < 12; i++)
            read_result();
    endtask

    // Twenty commands fill the command queue, both stages of every lane and the result queue.
    task automatic test_backpressure();
        logic [31:0] data;
        logic [1:0]  resp;
        for (int i = 0; i < 20; i++)
            issue_random_cmd(RESP_OKAY);
        wait_status(1, "a full command queue");
        axil_read(ADDR_STATUS, data, resp);
        check_data("STATUS", data, {20'd0, 4'(RES_DEPTH), 6'd0, 2'b11});
        issue_random_cmd(RESP_SLVERR);
        for (int i = 0; i < 20; i++)
            read_result();
        axil_read(ADDR_RESULT, data, resp);
        check_resp("RRESP", resp, RESP_SLVERR);
        check_data("RESULT", data, 32'h0);
    endtask

    initial begin
        repeat (TOTAL_CMDS * 200 + 2000) @(posedge clk);
        report_failure("Watchdog expired before the tests finished.");
    end

    initial begin
        wait (i_dut.i_assertions.fail_count != 0);
        report_failure("A protocol assertion failed.");
    end

    initial begin
        void'($urandom(79));
        reset   = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_opcodes();
        test_sources();
        test_burst();
        test_backpressure();

        if (i_dut.i_assertions.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_failure("Protocol assertions failed during the run.");
        end
    end

endmodule
